//--- logic/mmap_pkg.sv
// retro_apb address map
// NMI and APB vector types, 4 KB slave pages decoded on the upper 20 bits
`default_nettype none

package mmap_pkg;

  typedef logic [31:0] nmi_addr_t;
  typedef logic [31:0] nmi_data_t;
  typedef logic [3:0]  nmi_strb_t;
  typedef logic [11:0] apb_addr_t;

  // page offset width, bits above it select the slave
  localparam int PAGE_LSB = 12;

  localparam nmi_addr_t ARCHINFO_BASE = 32'h0300_0000;
  localparam nmi_addr_t RNG_BASE      = 32'h0300_1000;
  localparam nmi_addr_t TMR_BASE      = 32'h0300_2000;

  // one-hot select bit per slave
  localparam int SLV_ARCH = 0;
  localparam int SLV_RNG  = 1;
  localparam int SLV_TMR  = 2;
  localparam int SLV_NUM  = 3;

endpackage

`default_nettype wire

//--- logic/perip_pkg.sv
// retro_apb peripheral definitions
// register offsets, ID constants, timer and LFSR types, bridge FSM states
`default_nettype none

package perip_pkg;

  typedef logic [31:0] tmr_cnt_t;
  typedef logic [31:0] rng_state_t;

  typedef enum logic [1:0] {
    IDLE,
    SETUP,
    ACCESS
  } bridge_state_e;

  // archinfo
  localparam mmap_pkg::apb_addr_t ARCH_ID_OFS  = 12'h000;
  localparam mmap_pkg::apb_addr_t ARCH_VER_OFS = 12'h004;
  localparam mmap_pkg::nmi_data_t ARCH_ID_VAL  = 32'h5245_5452;
  localparam mmap_pkg::nmi_data_t ARCH_VER_VAL = 32'h0001_0002;

  // rng
  localparam mmap_pkg::apb_addr_t RNG_SEED_OFS = 12'h000;
  localparam mmap_pkg::apb_addr_t RNG_DATA_OFS = 12'h004;
  localparam rng_state_t          RNG_TAPS     = 32'h8020_0003;

  // timer
  localparam mmap_pkg::apb_addr_t TMR_CTRL_OFS = 12'h000;
  localparam mmap_pkg::apb_addr_t TMR_PSCR_OFS = 12'h004;
  localparam mmap_pkg::apb_addr_t TMR_CMP_OFS  = 12'h008;
  localparam mmap_pkg::apb_addr_t TMR_CNT_OFS  = 12'h00C;
  localparam mmap_pkg::apb_addr_t TMR_STAT_OFS = 12'h010;
  localparam int TMR_CTRL_EN_BIT = 0;
  localparam int TMR_CTRL_IE_BIT = 1;
  localparam int TMR_STAT_MF_BIT = 0;

endpackage

`default_nettype wire

//--- logic/nmi2apb.sv
// NMI to APB4 bridge
// accepts one NMI request at a time, decodes the 4 KB page into a
// one-hot slave select and runs a SETUP/ACCESS transfer on APB.
// unmapped pages finish in SETUP with zero read data.
`timescale 1ns/1ps
`default_nettype none

module nmi2apb (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                nmi_valid_i,
  input  mmap_pkg::nmi_addr_t nmi_addr_i,
  input  mmap_pkg::nmi_data_t nmi_wdata_i,
  input  mmap_pkg::nmi_strb_t nmi_wstrb_i,
  output logic                nmi_ready_o,
  output mmap_pkg::nmi_data_t nmi_rdata_o,
  output mmap_pkg::apb_addr_t paddr_o,
  output logic                pwrite_o,
  output mmap_pkg::nmi_data_t pwdata_o,
  output logic                penable_o,
  output logic                psel_arch_o,
  output logic                psel_rng_o,
  output logic                psel_tmr_o,
  input  mmap_pkg::nmi_data_t prdata_arch_i,
  input  mmap_pkg::nmi_data_t prdata_rng_i,
  input  mmap_pkg::nmi_data_t prdata_tmr_i,
  input  logic                pready_arch_i,
  input  logic                pready_rng_i,
  input  logic                pready_tmr_i
);
  import mmap_pkg::*;
  import perip_pkg::*;

  bridge_state_e      state_q, state_d;
  logic [SLV_NUM-1:0] sel_q, sel_d, psel_vec, pready_vec;
  apb_addr_t          addr_q;
  nmi_data_t          wdata_q, prdata_mux;
  logic               write_q, accept, mapped, slv_ready;

  assign accept = (state_q == IDLE) && nmi_valid_i;
  assign mapped = |sel_q;

  // page decode
  always_comb begin
    sel_d = '0;
    case (nmi_addr_i[31:PAGE_LSB])
      ARCHINFO_BASE[31:PAGE_LSB]: sel_d[SLV_ARCH] = 1'b1;
      RNG_BASE[31:PAGE_LSB]:      sel_d[SLV_RNG]  = 1'b1;
      TMR_BASE[31:PAGE_LSB]:      sel_d[SLV_TMR]  = 1'b1;
      default:                    sel_d = '0;
    endcase
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (nmi_valid_i)
          state_d = SETUP;
      end
      SETUP:   state_d = mapped ? ACCESS : IDLE;
      ACCESS: begin
        if (slv_ready)
          state_d = IDLE;
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
      sel_q   <= '0;
    end else begin
      state_q <= state_d;
      if (accept)
        sel_q <= sel_d;
    end
  end

  // request payload held for the whole transfer
  always_ff @(posedge clk_i) begin
    if (accept) begin
      addr_q  <= nmi_addr_i[PAGE_LSB-1:0];
      wdata_q <= nmi_wdata_i;
      write_q <= |nmi_wstrb_i;
    end
  end

  assign psel_vec   = (state_q != IDLE) ? sel_q : '0;
  assign pready_vec = {pready_tmr_i, pready_rng_i, pready_arch_i};
  assign slv_ready  = |(sel_q & pready_vec);

  always_comb begin
    prdata_mux = '0;
    if (sel_q[SLV_ARCH])
      prdata_mux = prdata_arch_i;
    if (sel_q[SLV_RNG])
      prdata_mux = prdata_rng_i;
    if (sel_q[SLV_TMR])
      prdata_mux = prdata_tmr_i;
  end

  assign psel_arch_o = psel_vec[SLV_ARCH];
  assign psel_rng_o  = psel_vec[SLV_RNG];
  assign psel_tmr_o  = psel_vec[SLV_TMR];
  assign penable_o   = (state_q == ACCESS);
  assign paddr_o     = addr_q;
  assign pwrite_o    = write_q;
  assign pwdata_o    = wdata_q;

  // mapped pages finish in ACCESS and unmapped ones in SETUP
  assign nmi_ready_o = ((state_q == ACCESS) && slv_ready) || ((state_q == SETUP) && !mapped);
  assign nmi_rdata_o = (state_q == ACCESS) ? prdata_mux : '0;

  a_psel_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $onehot0(psel_vec))
    else $error("nmi2apb: more than one psel active");

  // ACCESS must follow a SETUP to the same slave
  a_penable_psel: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    penable_o |-> (|psel_vec) && ($past(psel_vec) == psel_vec))
    else $error("nmi2apb: penable without a matching psel");

  // ready is a one-cycle pulse that hands the bridge back to IDLE
  a_ready_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    nmi_ready_o |=> (state_q == IDLE) && !nmi_ready_o)
    else $error("nmi2apb: nmi_ready_o not a single pulse back to IDLE");

endmodule

`default_nettype wire

//--- logic/apb4_archinfo.sv
// architecture info slave
// read-only ID and version words, other offsets read as zero
`timescale 1ns/1ps
`default_nettype none

module apb4_archinfo (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                psel_i,
  input  logic                penable_i,
  input  logic                pwrite_i,
  input  mmap_pkg::apb_addr_t paddr_i,
  output mmap_pkg::nmi_data_t prdata_o,
  output logic                pready_o
);
  import perip_pkg::*;

  logic rd_setup;

  // latch read data in SETUP so it is stable for ACCESS
  assign rd_setup = psel_i && !penable_i && !pwrite_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      prdata_o <= '0;
    end else if (rd_setup) begin
      case (paddr_i)
        ARCH_ID_OFS:  prdata_o <= ARCH_ID_VAL;
        ARCH_VER_OFS: prdata_o <= ARCH_VER_VAL;
        default:      prdata_o <= '0;
      endcase
    end
  end

  assign pready_o = 1'b1;

endmodule

`default_nettype wire

//--- logic/apb4_rng.sv
// random number slave
// 32-bit Galois LFSR, loaded through SEED and stepped on every DATA read
`timescale 1ns/1ps
`default_nettype none

module apb4_rng (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                psel_i,
  input  logic                penable_i,
  input  logic                pwrite_i,
  input  mmap_pkg::apb_addr_t paddr_i,
  input  mmap_pkg::nmi_data_t pwdata_i,
  output mmap_pkg::nmi_data_t prdata_o,
  output logic                pready_o
);
  import perip_pkg::*;

  rng_state_t state_q;
  logic       wr_seed, rd_data;

  function automatic rng_state_t lfsr_step(input rng_state_t s);
    rng_state_t nxt;
    nxt = s >> 1;
    if (s[0])
      nxt = nxt ^ RNG_TAPS;
    return nxt;
  endfunction

  assign wr_seed = psel_i && penable_i && pwrite_i && (paddr_i == RNG_SEED_OFS);
  assign rd_data = psel_i && penable_i && !pwrite_i && (paddr_i == RNG_DATA_OFS);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= 32'd1;
    end else if (wr_seed) begin
      // all-zero is the lock-up state
      state_q <= (pwdata_i == '0) ? 32'd1 : pwdata_i;
    end else if (rd_data) begin
      state_q <= lfsr_step(state_q);
    end
  end

  // current state goes out, the step lands at the end of ACCESS
  assign prdata_o = (paddr_i == RNG_DATA_OFS) ? state_q : '0;
  assign pready_o = 1'b1;

  a_state_nonzero: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    state_q != '0)
    else $error("apb4_rng: LFSR reached the all-zero state");

endmodule

`default_nettype wire

//--- logic/apb4_tmr.sv
// compare timer slave
// prescaler counts 0..PSCR, each wrap bumps CNT; CNT == CMP on a wrap
// restarts CNT and sets the match flag. irq is flag and ie, registered.
`timescale 1ns/1ps
`default_nettype none

module apb4_tmr (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                psel_i,
  input  logic                penable_i,
  input  logic                pwrite_i,
  input  mmap_pkg::apb_addr_t paddr_i,
  input  mmap_pkg::nmi_data_t pwdata_i,
  output mmap_pkg::nmi_data_t prdata_o,
  output logic                pready_o,
  output logic                tmr_irq_o
);
  import perip_pkg::*;

  logic     ctrl_en_q, ctrl_ie_q, stat_q;
  tmr_cnt_t pscr_q, cmp_q, cnt_q, psc_q;
  logic     apb_wr, cmp_wr, stat_clr, tick, cnt_match;

  assign apb_wr    = psel_i && penable_i && pwrite_i;
  assign cmp_wr    = apb_wr && (paddr_i == TMR_CMP_OFS);
  assign stat_clr  = apb_wr && (paddr_i == TMR_STAT_OFS) && pwdata_i[TMR_STAT_MF_BIT];
  assign tick      = ctrl_en_q && (psc_q == pscr_q);
  assign cnt_match = (cnt_q == cmp_q);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ctrl_en_q <= 1'b0;
      ctrl_ie_q <= 1'b0;
      pscr_q    <= '0;
      cmp_q     <= '0;
    end else if (apb_wr) begin
      case (paddr_i)
        TMR_CTRL_OFS: begin
          ctrl_en_q <= pwdata_i[TMR_CTRL_EN_BIT];
          ctrl_ie_q <= pwdata_i[TMR_CTRL_IE_BIT];
        end
        TMR_PSCR_OFS: pscr_q <= pwdata_i;
        TMR_CMP_OFS:  cmp_q  <= pwdata_i;
        default:      ;
      endcase
    end
  end

  // a new compare value restarts the count
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      psc_q <= '0;
      cnt_q <= '0;
    end else if (cmp_wr) begin
      psc_q <= '0;
      cnt_q <= '0;
    end else if (tick) begin
      psc_q <= '0;
      cnt_q <= cnt_match ? '0 : cnt_q + 1'b1;
    end else if (ctrl_en_q) begin
      psc_q <= psc_q + 1'b1;
    end
  end

  // set wins over a clear in the same cycle
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      stat_q    <= 1'b0;
      tmr_irq_o <= 1'b0;
    end else begin
      if (tick && cnt_match)
        stat_q <= 1'b1;
      else if (stat_clr)
        stat_q <= 1'b0;
      tmr_irq_o <= stat_q && ctrl_ie_q;
    end
  end

  always_comb begin
    prdata_o = '0;
    case (paddr_i)
      TMR_CTRL_OFS: begin
        prdata_o[TMR_CTRL_EN_BIT] = ctrl_en_q;
        prdata_o[TMR_CTRL_IE_BIT] = ctrl_ie_q;
      end
      TMR_PSCR_OFS: prdata_o = pscr_q;
      TMR_CMP_OFS:  prdata_o = cmp_q;
      TMR_CNT_OFS:  prdata_o = cnt_q;
      TMR_STAT_OFS: prdata_o[TMR_STAT_MF_BIT] = stat_q;
      default:      prdata_o = '0;
    endcase
  end

  assign pready_o = 1'b1;

  a_cnt_in_range: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (ctrl_en_q && (cmp_q != '0)) |-> (cnt_q <= cmp_q))
    else $error("apb4_tmr: CNT ran past CMP");

endmodule

`default_nettype wire

//--- logic/ip_apb_wrapper.sv
// retro_apb peripheral subsystem top
// NMI port in, bridge fans out to archinfo, rng and timer over APB4;
// irq_o carries the timer interrupt
`timescale 1ns/1ps
`default_nettype none

module ip_apb_wrapper (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                nmi_valid_i,
  input  mmap_pkg::nmi_addr_t nmi_addr_i,
  input  mmap_pkg::nmi_data_t nmi_wdata_i,
  input  mmap_pkg::nmi_strb_t nmi_wstrb_i,
  output logic                nmi_ready_o,
  output mmap_pkg::nmi_data_t nmi_rdata_o,
  output logic                irq_o
);
  import mmap_pkg::*;

  // shared APB request lines
  apb_addr_t paddr;
  nmi_data_t pwdata;
  logic      pwrite, penable;

  // per-slave select and response
  logic      psel_arch, psel_rng, psel_tmr;
  logic      pready_arch, pready_rng, pready_tmr;
  nmi_data_t prdata_arch, prdata_rng, prdata_tmr;

  nmi2apb u_nmi2apb (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .nmi_valid_i   (nmi_valid_i),
    .nmi_addr_i    (nmi_addr_i),
    .nmi_wdata_i   (nmi_wdata_i),
    .nmi_wstrb_i   (nmi_wstrb_i),
    .nmi_ready_o   (nmi_ready_o),
    .nmi_rdata_o   (nmi_rdata_o),
    .paddr_o       (paddr),
    .pwrite_o      (pwrite),
    .pwdata_o      (pwdata),
    .penable_o     (penable),
    .psel_arch_o   (psel_arch),
    .psel_rng_o    (psel_rng),
    .psel_tmr_o    (psel_tmr),
    .prdata_arch_i (prdata_arch),
    .prdata_rng_i  (prdata_rng),
    .prdata_tmr_i  (prdata_tmr),
    .pready_arch_i (pready_arch),
    .pready_rng_i  (pready_rng),
    .pready_tmr_i  (pready_tmr)
  );

  apb4_archinfo u_apb4_archinfo (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .psel_i    (psel_arch),
    .penable_i (penable),
    .pwrite_i  (pwrite),
    .paddr_i   (paddr),
    .prdata_o  (prdata_arch),
    .pready_o  (pready_arch)
  );

  apb4_rng u_apb4_rng (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .psel_i    (psel_rng),
    .penable_i (penable),
    .pwrite_i  (pwrite),
    .paddr_i   (paddr),
    .pwdata_i  (pwdata),
    .prdata_o  (prdata_rng),
    .pready_o  (pready_rng)
  );

  apb4_tmr u_apb4_tmr (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .psel_i    (psel_tmr),
    .penable_i (penable),
    .pwrite_i  (pwrite),
    .paddr_i   (paddr),
    .pwdata_i  (pwdata),
    .prdata_o  (prdata_tmr),
    .pready_o  (pready_tmr),
    .tmr_irq_o (irq_o)
  );

endmodule

`default_nettype wire

//--- tests/ip_apb_wrapper_tb.sv
// retro_apb subsystem testbench
// directed NMI tests of archinfo, rng, timer and the bridge page decode,
// with a Galois LFSR reference model for the rng sequence
`timescale 1ns/1ps
`default_nettype none

module ip_apb_wrapper_tb;
  import mmap_pkg::*;
  import perip_pkg::*;

  // roughly 40 accesses of 3 to 4 cycles plus about 150 timer cycles, wide margin
  localparam int TIMEOUT_CYCLES  = 4000;
  localparam int IRQ_WAIT_CYCLES = 40;

  logic      clk = 1'b0;
  logic      rst_n;
  logic      nmi_valid;
  nmi_addr_t nmi_addr;
  nmi_data_t nmi_wdata;
  nmi_strb_t nmi_wstrb;
  logic      nmi_ready;
  nmi_data_t nmi_rdata;
  logic      irq;

  integer seed;
  int     errors = 0;
  int     checks = 0;
  int     cycle_cnt = 0;

  ip_apb_wrapper dut (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .nmi_valid_i (nmi_valid),
    .nmi_addr_i  (nmi_addr),
    .nmi_wdata_i (nmi_wdata),
    .nmi_wstrb_i (nmi_wstrb),
    .nmi_ready_o (nmi_ready),
    .nmi_rdata_o (nmi_rdata),
    .irq_o       (irq)
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout: run stopped after %0d cycles", cycle_cnt);
      $display("*** FAILED ***");
      $finish;
    end
  end

  task automatic check_eq(input string name, input nmi_data_t expected,
                          input nmi_data_t actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("CHECK FAILED %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
    end
  endtask

  function automatic nmi_addr_t reg_addr(input nmi_addr_t base, input apb_addr_t ofs);
    return {base[31:PAGE_LSB], ofs};
  endfunction

  // reference: shift right, fold in the taps when the bit shifted out was 1
  function automatic rng_state_t galois_step(input rng_state_t s);
    return (s >> 1) ^ (s[0] ? RNG_TAPS : 32'h0);
  endfunction

  // called on a falling edge; cycles counts falling edges until nmi_ready_o
  task automatic nmi_access(input nmi_addr_t addr, input nmi_data_t wdata,
                            input nmi_strb_t wstrb, output nmi_data_t rdata,
                            output int cycles);
    nmi_valid = 1'b1;
    nmi_addr  = addr;
    nmi_wdata = wdata;
    nmi_wstrb = wstrb;
    cycles    = 0;
    do begin
      @(negedge clk);
      cycles++;
    end while (!nmi_ready);
    rdata     = nmi_rdata;
    nmi_valid = 1'b0;
    nmi_wstrb = '0;
    // let the bridge return to IDLE before the next request
    @(negedge clk);
  endtask

  task automatic nmi_write(input nmi_addr_t addr, input nmi_data_t wdata);
    nmi_data_t rd;
    int        cycles;
    nmi_access(addr, wdata, 4'hF, rd, cycles);
  endtask

  task automatic nmi_read(input nmi_addr_t addr, output nmi_data_t rdata);
    int cycles;
    nmi_access(addr, '0, 4'h0, rdata, cycles);
  endtask

  task automatic test_archinfo();
    nmi_data_t rd;
    nmi_read(reg_addr(ARCHINFO_BASE, ARCH_ID_OFS), rd);
    check_eq("archinfo id", ARCH_ID_VAL, rd);
    nmi_read(reg_addr(ARCHINFO_BASE, ARCH_VER_OFS), rd);
    check_eq("archinfo version", ARCH_VER_VAL, rd);
    nmi_write(reg_addr(ARCHINFO_BASE, ARCH_ID_OFS), $random(seed));
    nmi_read(reg_addr(ARCHINFO_BASE, ARCH_ID_OFS), rd);
    check_eq("archinfo id after write", ARCH_ID_VAL, rd);
  endtask

  task automatic test_rng();
    rng_state_t model;
    nmi_data_t  rd;
    int         i;
    model = $random(seed);
    if (model == '0)
      model = 32'd1;
    nmi_write(reg_addr(RNG_BASE, RNG_SEED_OFS), model);
    for (i = 0; i < 8; i++) begin
      nmi_read(reg_addr(RNG_BASE, RNG_DATA_OFS), rd);
      check_eq("rng sequence", model, rd);
      model = galois_step(model);
    end
    // zero seed must fall back to 1
    nmi_write(reg_addr(RNG_BASE, RNG_SEED_OFS), '0);
    model = 32'd1;
    for (i = 0; i < 2; i++) begin
      nmi_read(reg_addr(RNG_BASE, RNG_DATA_OFS), rd);
      check_eq("rng zero seed", model, rd);
      model = galois_step(model);
    end
  endtask

  task automatic test_decode();
    nmi_addr_t addr;
    nmi_data_t rd;
    int        cycles;
    addr = $random(seed);
    // nothing is mapped in the upper half
    addr[31] = 1'b1;
    nmi_access(addr, '0, 4'h0, rd, cycles);
    check_eq("unmapped rdata", 32'h0, rd);
    check_eq("unmapped latency", 32'd1, cycles);
    nmi_access(reg_addr(ARCHINFO_BASE, ARCH_VER_OFS), '0, 4'h0, rd, cycles);
    check_eq("mapped rdata", ARCH_VER_VAL, rd);
    check_eq("mapped latency", 32'd2, cycles);
  endtask

  task automatic test_tmr_regs();
    nmi_data_t pscr, cmp, rd;
    pscr = $random(seed);
    cmp  = $random(seed);
    nmi_write(reg_addr(TMR_BASE, TMR_PSCR_OFS), pscr);
    nmi_write(reg_addr(TMR_BASE, TMR_CMP_OFS), cmp);
    nmi_write(reg_addr(TMR_BASE, TMR_CTRL_OFS), 32'h2);
    nmi_read(reg_addr(TMR_BASE, TMR_PSCR_OFS), rd);
    check_eq("tmr pscr readback", pscr, rd);
    nmi_read(reg_addr(TMR_BASE, TMR_CMP_OFS), rd);
    check_eq("tmr cmp readback", cmp, rd);
    nmi_read(reg_addr(TMR_BASE, TMR_CTRL_OFS), rd);
    check_eq("tmr ctrl readback", 32'h2, rd);
  endtask

  task automatic test_tmr_irq();
    nmi_data_t rd;
    int        waited;
    int        high_seen;
    nmi_write(reg_addr(TMR_BASE, TMR_PSCR_OFS), 32'd1);
    nmi_write(reg_addr(TMR_BASE, TMR_CMP_OFS), 32'd5);
    nmi_write(reg_addr(TMR_BASE, TMR_CTRL_OFS), 32'h3);
    waited = 0;
    while (!irq && waited < IRQ_WAIT_CYCLES) begin
      @(negedge clk);
      waited++;
    end
    if (!irq) begin
      errors++;
      $display("timer irq did not rise within %0d cycles", IRQ_WAIT_CYCLES);
    end
    nmi_read(reg_addr(TMR_BASE, TMR_CNT_OFS), rd);
    check_eq("tmr count range", 32'd1, (rd <= 32'd5) ? 32'd1 : 32'd0);
    // stop counting, keep ie, then clear the flag
    nmi_write(reg_addr(TMR_BASE, TMR_CTRL_OFS), 32'h2);
    nmi_write(reg_addr(TMR_BASE, TMR_STAT_OFS), 32'h1);
    @(negedge clk);
    check_eq("tmr irq after clear", 32'h0, {31'b0, irq});
    nmi_read(reg_addr(TMR_BASE, TMR_STAT_OFS), rd);
    check_eq("tmr stat after clear", 32'h0, rd);
    nmi_write(reg_addr(TMR_BASE, TMR_CTRL_OFS), 32'h1);
    high_seen = 0;
    repeat (IRQ_WAIT_CYCLES) begin
      @(negedge clk);
      if (irq)
        high_seen++;
    end
    check_eq("tmr irq masked", 32'h0, high_seen);
    nmi_read(reg_addr(TMR_BASE, TMR_STAT_OFS), rd);
    check_eq("tmr stat masked", 32'h1, rd);
    nmi_write(reg_addr(TMR_BASE, TMR_CTRL_OFS), 32'h0);
  endtask

  initial begin
    seed      = 27574;
    rst_n     = 1'b0;
    nmi_valid = 1'b0;
    nmi_addr  = '0;
    nmi_wdata = '0;
    nmi_wstrb = '0;
    repeat (8) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    check_eq("reset ready", 32'h0, {31'b0, nmi_ready});
    check_eq("reset irq", 32'h0, {31'b0, irq});
    test_archinfo();
    test_rng();
    test_decode();
    test_tmr_regs();
    test_tmr_irq();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

//--- retro_apb.f
logic/mmap_pkg.sv
logic/perip_pkg.sv
logic/nmi2apb.sv
logic/apb4_archinfo.sv
logic/apb4_rng.sv
logic/apb4_tmr.sv
logic/ip_apb_wrapper.sv
tests/ip_apb_wrapper_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the retro_apb testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert \
  --top-module ip_apb_wrapper_tb \
  -f retro_apb.f \
  -o sim_retro_apb &&
./obj_dir/sim_retro_apb | tee /dev/stderr | grep -qF '*** PASSED ***' &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
